//--- Bender.yml
package:
  name: memPipe

sources:
  - include_dirs:
      - .
    files:
      - memOpPkg.sv
      - cacheBusPkg.sv
      - loadAligner.sv
      - memStage.sv
      - dataCache.sv
      - memSubsystem.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbMemSubsystem.sv

//--- cacheBusPkg.sv
`include "memPipe_macros.svh"

package cacheBusPkg;

    // one access from the memory stage.
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic                   uncached;
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wdata;
        logic [3:0]             byteEnable;
    } cacheReq_t;

    // held until the sram answers with data ok.
    typedef struct packed {
        logic                   req;
        logic                   wr;
        logic [`DATA_WIDTH-1:0] addr;
        logic [3:0]             wstrb;
        logic [`DATA_WIDTH-1:0] wdata;
    } sramReq_t;

endpackage

//--- dataCache.sv
`timescale 1ns/10ps
`include "memPipe_macros.svh"

module dataCache (
    input  logic                   Clk,
    input  logic                   reset,
    input  cacheBusPkg::cacheReq_t cacheReq,
    output logic [`DATA_WIDTH-1:0] rdata,
    output logic                   hit,
    output cacheBusPkg::sramReq_t  sramReq,
    input  logic [`DATA_WIDTH-1:0] sramRdata,
    input  logic                   sramDataOk
);
    import cacheBusPkg::*;

    localparam int LINES = 1 << `CACHE_INDEX_BITS;

    logic [LINES-1:0]             lineValid;
    logic [`CACHE_TAG_BITS-1:0]   tagArr  [LINES];
    logic [`DATA_WIDTH-1:0]       dataArr [LINES];

    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [`CACHE_TAG_BITS-1:0]   tag;
    logic                         lineHit;
    logic                         needSram;
    logic                         ackNow;
    logic                         fillNow;
    logic                         storeHitNow;
    sramReq_t                     reqHeld;
    logic [`DATA_WIDTH-1:0]       mergedLine;

    assign index   = cacheReq.addr[2 +: `CACHE_INDEX_BITS];
    assign tag     = cacheReq.addr[`DATA_WIDTH-1 -: `CACHE_TAG_BITS];
    assign lineHit = lineValid[index] && (tagArr[index] == tag);

    // every store writes through, reads go out only on a miss or uncached.
    assign needSram = cacheReq.write
                   || (cacheReq.read && (cacheReq.uncached || !lineHit));

    assign ackNow      = reqHeld.req && sramDataOk;
    assign fillNow     = ackNow && !reqHeld.wr && !cacheReq.uncached;
    assign storeHitNow = ackNow && reqHeld.wr && lineHit;

    // a fill or a finished store counts as a hit in the ack cycle.
    assign hit = !cacheReq.uncached && (ackNow || (cacheReq.read && lineHit));

    assign rdata = (!cacheReq.uncached && lineHit) ? dataArr[index] : sramRdata;

    always_comb begin
        mergedLine = dataArr[index];
        for (int b = 0; b < 4; b++) begin
            if (reqHeld.wstrb[b]) begin
                mergedLine[8*b +: 8] = reqHeld.wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            lineValid <= '0;
        end else if (fillNow) begin
            lineValid[index] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (fillNow) begin
            tagArr[index]  <= tag;
            dataArr[index] <= sramRdata;
        end else if (storeHitNow) begin
            dataArr[index] <= mergedLine;
        end
    end

    // one transfer at a time.
    always_ff @(posedge Clk) begin
        if (reset) begin
            reqHeld.req <= 1'b0;
        end else if (reqHeld.req) begin
            if (sramDataOk) begin
                reqHeld.req <= 1'b0;
            end
        end else if (needSram) begin
            reqHeld.req   <= 1'b1;
            reqHeld.wr    <= cacheReq.write;
            reqHeld.addr  <= cacheReq.addr;
            reqHeld.wstrb <= cacheReq.byteEnable;
            reqHeld.wdata <= cacheReq.wdata;
        end
    end

    assign sramReq = reqHeld;

    assert property (@(posedge Clk) disable iff (reset)
        (sramReq.req && !sramDataOk) |=> $stable(sramReq));

endmodule

//--- loadAligner.sv
`timescale 1ns/10ps
`include "memPipe_macros.svh"

module loadAligner (
    input  memOpPkg::memOp_t       op,
    input  logic [`DATA_WIDTH-1:0] word,
    input  logic [1:0]             byteOff,
    input  logic [`DATA_WIDTH-1:0] rtValue,
    output logic [`DATA_WIDTH-1:0] loadValue
);
    import memOpPkg::*;

    logic [4:0]             rightShift;
    logic [4:0]             leftShift;
    logic [`DATA_WIDTH-1:0] shifted;
    logic [`DATA_WIDTH-1:0] leftMerge;
    logic [`DATA_WIDTH-1:0] rightMerge;

    assign rightShift = {byteOff, 3'b000};
    assign leftShift  = {~byteOff, 3'b000};

    // addressed byte or halfword lands in the low lanes.
    assign shifted = word >> rightShift;

    // lwl fills from the top, rt keeps the low bytes.
    assign leftMerge = (word << leftShift)
                     | (rtValue & ~({`DATA_WIDTH{1'b1}} << leftShift));

    // lwr fills from the bottom, rt keeps the high bytes.
    assign rightMerge = (word >> rightShift)
                      | (rtValue & ~({`DATA_WIDTH{1'b1}} >> rightShift));

    always_comb begin
        case (op)
            opLb: begin
                loadValue = {{(`DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            end
            opLbu: begin
                loadValue = {{(`DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            end
            opLh: begin
                loadValue = {{(`DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            end
            opLhu: begin
                loadValue = {{(`DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            end
            opLwl: begin
                loadValue = leftMerge;
            end
            opLwr: begin
                loadValue = rightMerge;
            end
            default: begin
                loadValue = word;
            end
        endcase
    end

endmodule

//--- memOpPkg.sv
`include "memPipe_macros.svh"

package memOpPkg;

    typedef enum logic [3:0] {
        opNone,
        opLb,
        opLbu,
        opLh,
        opLhu,
        opLw,
        opLwl,
        opLwr,
        opLl,
        opSb,
        opSh,
        opSw,
        opSwl,
        opSwr,
        opSc
    } memOp_t;

    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]   tag;
        logic [`CACHE_INDEX_BITS-1:0] index;
        logic [1:0]                   byteOff;
    } memAddr_t;

    // alu result, or the same bits read as an address.
    typedef union packed {
        logic [`DATA_WIDTH-1:0] value;
        memAddr_t               addr;
    } execResult_u;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0]  pc;
        memOp_t                  op;
        execResult_u             result;
        logic [`REG_ID_BITS-1:0] rtId;
        logic [`DATA_WIDTH-1:0]  rtValue;
        logic [`DATA_WIDTH-1:0]  scData;
        logic [3:0]              byteEnable;
        logic                    regWriteEnable;
        logic [`REG_ID_BITS-1:0] regNumber;
        logic [`TNEW_BITS-1:0]   tNew;
        logic                    readCp0;
        logic                    uncached;
    } execBundle_t;

    typedef struct packed {
        logic                    regWriteEnable;
        logic [3:0]              laneEnable;
        logic [`REG_ID_BITS-1:0] regId;
        logic [`DATA_WIDTH-1:0]  data;
        logic [`DATA_WIDTH-1:0]  pc;
        logic [`TNEW_BITS-1:0]   tNew;
    } wbBundle_t;

endpackage

//--- memPipe_macros.svh
`ifndef MEMPIPE_MACROS_SVH
`define MEMPIPE_MACROS_SVH

// machine word.
`define DATA_WIDTH 32

// register number width.
`define REG_ID_BITS 5

// result-ready countdown width.
`define TNEW_BITS 4

// direct-mapped geometry, one word per line.
`define CACHE_INDEX_BITS 6

// whatever the index and the byte offset leave over.
`define CACHE_TAG_BITS (32 - `CACHE_INDEX_BITS - 2)

`endif

//--- memStage.sv
`timescale 1ns/10ps
`include "memPipe_macros.svh"

module memStage (
    input  logic                    Clk,
    input  logic                    reset,
    input  logic                    exceptionFlush,
    input  memOpPkg::execBundle_t   execBundle,
    input  logic [`DATA_WIDTH-1:0]  cp0Value,
    output cacheBusPkg::cacheReq_t  cacheReq,
    input  logic [`DATA_WIDTH-1:0]  cacheRdata,
    input  logic                    hit,
    input  logic                    sramDataOk,
    output logic                    dmStall,
    output memOpPkg::wbBundle_t     wbBundle
);
    import memOpPkg::*;

    logic                   isRead;
    logic                   isWrite;
    logic [1:0]             byteOff;
    logic [`DATA_WIDTH-1:0] rtFwd;
    logic [`DATA_WIDTH-1:0] storeData;
    logic [`DATA_WIDTH-1:0] stageWord;
    logic [`DATA_WIDTH-1:0] loadValue;
    wbBundle_t              wbNext;

    // rt produced by the instruction now in writeback.
    assign rtFwd = (execBundle.rtId != '0 && wbBundle.regWriteEnable
                    && wbBundle.regId == execBundle.rtId)
                 ? wbBundle.data : execBundle.rtValue;

    assign byteOff = execBundle.result.addr.byteOff;

    assign isRead = execBundle.op inside {opLb, opLbu, opLh, opLhu, opLw,
                                          opLwl, opLwr, opLl};
    assign isWrite = execBundle.op inside {opSb, opSh, opSw, opSwl, opSwr, opSc};

    // swl puts the high rt bytes into the low lanes.
    assign storeData = (execBundle.op == opSwl) ? (rtFwd >> {~byteOff, 3'b000})
                                                : (rtFwd << {byteOff, 3'b000});

    assign cacheReq.read       = isRead;
    assign cacheReq.write      = isWrite;
    assign cacheReq.uncached   = execBundle.uncached;
    assign cacheReq.addr       = execBundle.result.value;
    assign cacheReq.wdata      = storeData;
    assign cacheReq.byteEnable = isWrite ? execBundle.byteEnable : 4'b0000;

    assign dmStall = (isRead || isWrite)
                   && ((execBundle.uncached && !sramDataOk)
                       || (!execBundle.uncached && !hit));

    always_comb begin
        if (isRead) begin
            stageWord = cacheRdata;
        end else if (execBundle.readCp0) begin
            stageWord = cp0Value;
        end else begin
            stageWord = execBundle.result.value;
        end
    end

    loadAligner aligner (
        .op        (execBundle.op),
        .word      (stageWord),
        .byteOff   (byteOff),
        .rtValue   (rtFwd),
        .loadValue (loadValue)
    );

    always_comb begin
        wbNext.regWriteEnable = execBundle.regWriteEnable;
        wbNext.laneEnable     = {4{execBundle.regWriteEnable}};
        wbNext.regId          = execBundle.regNumber;
        wbNext.data           = (execBundle.op == opSc) ? execBundle.scData : loadValue;
        wbNext.pc             = execBundle.pc;
        // tnew saturates at zero.
        wbNext.tNew = (execBundle.tNew == '0) ? '0 : execBundle.tNew - 1'b1;
    end

    // flush wins over a pending stall.
    always_ff @(posedge Clk) begin
        if (reset || exceptionFlush) begin
            wbBundle <= '0;
        end else if (!dmStall) begin
            wbBundle <= wbNext;
        end
    end

    assert property (@(posedge Clk) disable iff (reset)
        !(cacheReq.read && cacheReq.write));

    // no access, so the cache must never hold the stage.
    assert property (@(posedge Clk) disable iff (reset)
        (execBundle.op == opNone) |-> !dmStall);

endmodule

//--- memSubsystem.sv
`timescale 1ns/10ps
`include "memPipe_macros.svh"

module memSubsystem (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic                   exceptionFlush,
    input  memOpPkg::execBundle_t  execBundle,
    input  logic [`DATA_WIDTH-1:0] cp0Value,
    output logic                   dmStall,
    output memOpPkg::wbBundle_t    wbBundle,
    output cacheBusPkg::sramReq_t  sramReq,
    input  logic [`DATA_WIDTH-1:0] sramRdata,
    input  logic                   sramDataOk
);
    import cacheBusPkg::*;

    cacheReq_t              cacheReq;
    logic [`DATA_WIDTH-1:0] cacheRdata;
    logic                   cacheHit;

    memStage stage (
        .Clk            (Clk),
        .reset          (reset),
        .exceptionFlush (exceptionFlush),
        .execBundle     (execBundle),
        .cp0Value       (cp0Value),
        .cacheReq       (cacheReq),
        .cacheRdata     (cacheRdata),
        .hit            (cacheHit),
        .sramDataOk     (sramDataOk),
        .dmStall        (dmStall),
        .wbBundle       (wbBundle)
    );

    // write-through cache in front of the sram port.
    dataCache cache (
        .Clk        (Clk),
        .reset      (reset),
        .cacheReq   (cacheReq),
        .rdata      (cacheRdata),
        .hit        (cacheHit),
        .sramReq    (sramReq),
        .sramRdata  (sramRdata),
        .sramDataOk (sramDataOk)
    );

endmodule

//--- tbMemSubsystem.sv
`timescale 1ns/10ps

module tbMemSubsystem;
    import memOpPkg::*;
    import cacheBusPkg::*;

    localparam int BUNDLE_BUDGET = 140;

    logic        Clk = 1'b0;
    logic        reset = 1'b1;
    logic        exceptionFlush = 1'b0;
    execBundle_t execBundle = '0;
    logic [31:0] cp0Value = '0;
    logic        dmStall;
    wbBundle_t   wbBundle;
    sramReq_t    sramReq;
    logic [31:0] sramRdata = '0;
    logic        sramDataOk = 1'b0;

    integer      seed = 32'h5ac4_f4bb;
    logic [31:0] sramMem [1024];
    logic [31:0] shadowMem [1024];
    wbBundle_t   expQ [$];
    wbBundle_t   expNow;
    wbBundle_t   lastWb = '0;
    logic [31:0] pcCount = 32'h0040_0000;
    int          testErrors = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          waitCnt = 0;
    memOp_t      storeOps [4] = '{opSb, opSh, opSwl, opSwr};

    always #2 Clk = ~Clk;

    memSubsystem dut (
        .Clk            (Clk),
        .reset          (reset),
        .exceptionFlush (exceptionFlush),
        .execBundle     (execBundle),
        .cp0Value       (cp0Value),
        .dmStall        (dmStall),
        .wbBundle       (wbBundle),
        .sramReq        (sramReq),
        .sramRdata      (sramRdata),
        .sramDataOk     (sramDataOk)
    );

    function automatic logic [31:0] fillWord(int unsigned i);
        return (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
    endfunction

    function automatic logic [3:0] laneMask(memOp_t op, logic [1:0] off);
        case (op)
            opSb:       return 4'b0001 << off;
            opSh:       return 4'b0011 << off;
            opSwl:      return 4'b1111 >> (2'd3 - off);
            opSwr:      return 4'b1111 << off;
            opSw, opSc: return 4'b1111;
            default:    return 4'b0000;
        endcase
    endfunction

    // memory word after a store, lane by lane.
    function automatic logic [31:0] storeWord(memOp_t op, logic [1:0] off,
                                               logic [31:0] rt, logic [31:0] old);
        logic [31:0] w;
        int          o;
        int          src;
        w = old;
        o = off;
        for (int k = 0; k < 4; k++) begin
            src = -1;
            case (op)
                opSb:       if (k == o) src = 0;
                opSh:       if (k == o || k == o + 1) src = k - o;
                opSw, opSc: src = k;
                opSwl:      if (k <= o) src = 3 - o + k;
                opSwr:      if (k >= o) src = k - o;
                default:    src = -1;
            endcase
            if (src >= 0) begin
                w[8*k +: 8] = rt[8*src +: 8];
            end
        end
        return w;
    endfunction

    // expected writeback for one accepted bundle.
    function automatic wbBundle_t refResult(execBundle_t eb, logic [31:0] rt,
                                            logic [31:0] cp0, logic [31:0] memWord);
        int          o;
        logic [31:0] d;
        wbBundle_t   r;
        o = eb.result.addr.byteOff;
        d = '0;
        case (eb.op)
            opLb:  d = {{24{memWord[8*o+7]}}, memWord[8*o +: 8]};
            opLbu: d = {24'h0, memWord[8*o +: 8]};
            opLh:  d = {{16{memWord[8*o+15]}}, memWord[8*o +: 16]};
            opLhu: d = {16'h0, memWord[8*o +: 16]};
            opLw, opLl: d = memWord;
            opLwl: begin
                for (int k = 0; k < 4; k++) begin
                    d[8*k +: 8] = (k >= 3 - o) ? memWord[8*(k-3+o) +: 8] : rt[8*k +: 8];
                end
            end
            opLwr: begin
                for (int k = 0; k < 4; k++) begin
                    d[8*k +: 8] = (k <= 3 - o) ? memWord[8*(k+o) +: 8] : rt[8*k +: 8];
                end
            end
            opSc:    d = eb.scData;
            default: d = eb.readCp0 ? cp0 : eb.result.value;
        endcase
        r.regWriteEnable = eb.regWriteEnable;
        r.laneEnable     = {4{eb.regWriteEnable}};
        r.regId          = eb.regNumber;
        r.data           = d;
        r.pc             = eb.pc;
        r.tNew           = (eb.tNew == 0) ? 4'd0 : eb.tNew - 4'd1;
        return r;
    endfunction

    function automatic execBundle_t makeBundle(memOp_t op, logic [31:0] addr,
                                               logic [4:0] rtId, logic [31:0] rtVal,
                                               logic [4:0] dest, logic unc);
        execBundle_t b;
        b = '0;
        b.op             = op;
        b.result.value   = addr;
        b.rtId           = rtId;
        b.rtValue        = rtVal;
        b.regWriteEnable = (dest != 0);
        b.regNumber      = dest;
        b.tNew           = 4'd2;
        b.uncached       = unc;
        return b;
    endfunction

    task automatic checkField(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            testErrors++;
        end
    endtask

    task automatic driveBundle(execBundle_t b);
        @(posedge Clk);
        #0.5;
        b.pc = pcCount;
        b.byteEnable = laneMask(b.op, b.result.addr.byteOff);
        pcCount += 4;
        execBundle = b;
    endtask

    // waits for a cycle without stall, then books the expected result.
    task automatic acceptBundle();
        logic [31:0] rt;
        int          idx;
        wbBundle_t   e;
        do @(negedge Clk); while (dmStall);
        rt = (execBundle.rtId != 0 && lastWb.regWriteEnable
              && lastWb.regId == execBundle.rtId) ? lastWb.data : execBundle.rtValue;
        idx = execBundle.result.value[11:2];
        e = refResult(execBundle, rt, cp0Value, shadowMem[idx]);
        if (laneMask(execBundle.op, execBundle.result.addr.byteOff) != 0) begin
            shadowMem[idx] = storeWord(execBundle.op, execBundle.result.addr.byteOff,
                                       rt, shadowMem[idx]);
        end
        expQ.push_back(e);
        lastWb = e;
    endtask

    task automatic send(execBundle_t b);
        driveBundle(b);
        acceptBundle();
    endtask

    task automatic finishTest(string name);
        @(posedge Clk);
        #0.5;
        execBundle = '0;
        lastWb = '0;
        #1.5;
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, testErrors);
        end
        testErrors = 0;
    endtask

    // sram with a random answer delay of 1 to 4 cycles.
    always @(posedge Clk) begin
        #0.5;
        if (reset) begin
            sramDataOk = 1'b0;
            waitCnt = 0;
        end else if (sramDataOk) begin
            sramDataOk = 1'b0;
        end else if (sramReq.req) begin
            if (waitCnt == 0) begin
                waitCnt = 1 + ($random(seed) & 3);
            end
            waitCnt--;
            if (waitCnt == 0) begin
                for (int k = 0; k < 4; k++) begin
                    if (sramReq.wr && sramReq.wstrb[k]) begin
                        sramMem[sramReq.addr[11:2]][8*k +: 8] = sramReq.wdata[8*k +: 8];
                    end
                end
                sramRdata = sramMem[sramReq.addr[11:2]];
                sramDataOk = 1'b1;
            end
        end
    end

    always @(posedge Clk) begin
        #1;
        if (expQ.size() > 0) begin
            expNow = expQ.pop_front();
            checkField("wbBundle.regWriteEnable", expNow.regWriteEnable,
                       wbBundle.regWriteEnable);
            checkField("wbBundle.laneEnable", expNow.laneEnable, wbBundle.laneEnable);
            checkField("wbBundle.regId", expNow.regId, wbBundle.regId);
            checkField("wbBundle.data", expNow.data, wbBundle.data);
            checkField("wbBundle.pc", expNow.pc, wbBundle.pc);
            checkField("wbBundle.tNew", expNow.tNew, wbBundle.tNew);
        end
    end

    initial begin
        #((16 + BUNDLE_BUDGET * 6) * 4 + 2000);
        $display("watchdog: run did not finish in time, the DUT appears to hang");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] rt;
        logic        unc;
        execBundle_t b;
        for (int i = 0; i < 1024; i++) begin
            sramMem[i] = fillWord(i);
            shadowMem[i] = fillWord(i);
        end
        repeat (16) @(posedge Clk);
        #0.5;
        reset = 1'b0;

        for (int i = 0; i < 8; i++) begin
            addr = $random(seed) & 32'hffc;
            unc = i[0];
            rt = $random(seed);
            send(makeBundle(opSw, addr, 5'd0, rt, 5'd0, unc));
            send(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd2, unc));
            if (!unc) begin
                send(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd2, unc));
            end
        end
        finishTest("word round trip");

        addr = $random(seed) & 32'hffc;
        send(makeBundle(opSw, addr, 5'd0, $random(seed), 5'd0, 1'b0));
        for (int o = 0; o < 4; o++) begin
            send(makeBundle(opLb, addr + o, 5'd0, 32'h0, 5'd3, 1'b0));
            send(makeBundle(opLbu, addr + o, 5'd0, 32'h0, 5'd3, 1'b0));
            if (o % 2 == 0) begin
                send(makeBundle(opLh, addr + o, 5'd0, 32'h0, 5'd3, 1'b0));
                send(makeBundle(opLhu, addr + o, 5'd0, 32'h0, 5'd3, 1'b0));
            end
        end
        finishTest("sub-word loads");

        addr = $random(seed) & 32'hffc;
        send(makeBundle(opSw, addr, 5'd0, $random(seed), 5'd0, 1'b0));
        for (int o = 0; o < 4; o++) begin
            send(makeBundle(opLwl, addr + o, 5'd4, $random(seed), 5'd4, 1'b0));
            send(makeBundle(opLwr, addr + o, 5'd4, $random(seed), 5'd4, 1'b0));
        end
        // rt comes from the instruction in writeback.
        send(makeBundle(opNone, $random(seed), 5'd0, 32'h0, 5'd5, 1'b0));
        send(makeBundle(opLwl, addr + 1, 5'd5, 32'hdead_beef, 5'd6, 1'b0));
        send(makeBundle(opLwr, addr + 2, 5'd6, 32'h1234_5678, 5'd6, 1'b1));
        finishTest("lwl/lwr merge");

        addr = $random(seed) & 32'hffc;
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 4; o++) begin
                if (storeOps[s] != opSh || o % 2 == 0) begin
                    unc = o[0];
                    send(makeBundle(opSw, addr, 5'd0, $random(seed), 5'd0, unc));
                    send(makeBundle(storeOps[s], addr + o, 5'd0, $random(seed), 5'd0, unc));
                    send(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd8, 1'b0));
                end
            end
        end
        send(makeBundle(opNone, $random(seed), 5'd0, 32'h0, 5'd7, 1'b0));
        send(makeBundle(opSb, addr + 2, 5'd7, 32'hffff_ffff, 5'd0, 1'b0));
        send(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd8, 1'b0));
        finishTest("sub-word stores");

        for (int k = 0; k < 4; k++) begin
            b = makeBundle(opNone, $random(seed), 5'd0, 32'h0, 5'd10 + k, 1'b0);
            b.tNew = k;
            b.regWriteEnable = (k != 1);
            send(b);
        end
        b = makeBundle(opNone, $random(seed), 5'd0, 32'h0, 5'd12, 1'b0);
        b.readCp0 = 1'b1;
        driveBundle(b);
        cp0Value = $random(seed);
        acceptBundle();
        addr = $random(seed) & 32'hffc;
        b = makeBundle(opSc, addr, 5'd0, $random(seed), 5'd9, 1'b0);
        b.scData = 32'h1;
        send(b);
        send(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd9, 1'b0));
        finishTest("non-memory paths");

        // a writing instruction ahead leaves wbBundle nonzero at the flush edge.
        addr = $random(seed) & 32'hffc;
        send(makeBundle(opNone, $random(seed), 5'd0, 32'h0, 5'd4, 1'b0));
        driveBundle(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd3, 1'b1));
        exceptionFlush = 1'b1;
        @(negedge Clk);
        if (!dmStall) begin
            $display("uncached load did not stall in its first cycle at %0t", $time);
            testErrors++;
        end
        @(posedge Clk);
        #0.5;
        exceptionFlush = 1'b0;
        #0.5;
        if (wbBundle !== '0) begin
            $display("FAIL %0t wbBundle expected %h got %h", $time, 78'h0, wbBundle);
            testErrors++;
        end
        lastWb = '0;
        acceptBundle();
        finishTest("flush");

        // reset lands while an sram read is still outstanding.
        addr = $random(seed) & 32'hffc;
        driveBundle(makeBundle(opLw, addr, 5'd0, 32'h0, 5'd3, 1'b1));
        @(posedge Clk);
        #0.5;
        if (!sramReq.req) begin
            $display("uncached load sent no sram request at %0t", $time);
            testErrors++;
        end
        reset = 1'b1;
        execBundle = makeBundle(opNone, $random(seed), 5'd0, 32'h0, 5'd5, 1'b0);
        repeat (2) @(posedge Clk);
        #0.5;
        reset = 1'b0;
        @(negedge Clk);
        checkField("dmStall", 32'h0, dmStall);
        checkField("sramReq.req", 32'h0, sramReq.req);
        if (wbBundle !== '0) begin
            $display("wbBundle was not cleared by reset at %0t", $time);
            testErrors++;
        end
        finishTest("reset");

        $display("tests passed %0d, failed %0d", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+.
memOpPkg.sv
cacheBusPkg.sv
loadAligner.sv
memStage.sv
dataCache.sv
memSubsystem.sv
tbMemSubsystem.sv
